/* Bender.yml */
package:
  name: multicycle_controller

sources:
  - files:
      - hw/ctrl_pkg.sv
      - hw/execute_unit.sv
      - hw/mem_access_unit.sv
      - hw/instr_sequencer.sv
      - hw/multicycle_controller.sv
  - target: test
    files:
      - bench/wb_mem_model.sv
      - bench/controller_tb.sv

/* all.f */
hw/ctrl_pkg.sv
hw/execute_unit.sv
hw/mem_access_unit.sv
hw/instr_sequencer.sv
hw/multicycle_controller.sv
bench/wb_mem_model.sv
bench/controller_tb.sv

/* bench/controller_tb.sv */
`timescale 1ns/10ps

module controller_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS     = 24;

    localparam logic [1:0] SZ_B = ctrl_pkg::SIZE_BYTE;
    localparam logic [1:0] SZ_H = ctrl_pkg::SIZE_HALF;
    localparam logic [1:0] SZ_W = ctrl_pkg::SIZE_WORD;

    typedef struct packed
    {
        logic [6:0] opcode;
        logic [2:0] func3;
        logic       cmp;
        logic [1:0] reg_writes;
        logic       wb_mem;
        logic       alu_src;
        logic [1:0] bus_cycles;
        logic       we;
        logic [1:0] size;
        logic       branch;
        logic       illegal;
        logic [3:0] latency;    // Cycle of instr_done after the go sample or 0 when ack decides
    } test_row_t;

    logic                    clk;
    logic                    reset;
    logic                    go;
    logic                    comparator;
    logic                    mem_ack;
    ctrl_pkg::instr_fields_t instr;
    ctrl_pkg::ctrl_out_t     ctrl;
    ctrl_pkg::mem_req_t      mem_req;
    logic                    instr_done;
    logic                    illegal;
    logic [31:0]             bus_count;
    logic                    last_we;
    ctrl_pkg::mem_size_e     last_size;

    test_row_t rows [NUM_ROWS];
    int        errors = 0;
    int        checks = 0;

    // Observer state for the instruction in flight
    bit active    = 0;
    bit seen_go   = 0;
    bit done_flag = 0;
    int rel;
    int ir_count;
    int ir_cycle;
    int pc_seq_count;
    int pc_seq_cycle;
    int pc_branch_count;
    int write_count;
    int write_from_mem;
    int write_after_ack;    // Last reg_write came after an ack
    int ack_seen;
    int alu_seen;
    int illegal_cycles;
    int done_cycle;
    int illegal_at_done;

    multicycle_controller multicycle_controller_i
    (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .instr      (instr),
        .comparator (comparator),
        .mem_ack    (mem_ack),
        .ctrl       (ctrl),
        .mem_req    (mem_req),
        .instr_done (instr_done),
        .illegal    (illegal)
    );

    wb_mem_model mem_model_i
    (
        .clk         (clk),
        .reset       (reset),
        .mem_req     (mem_req),
        .ack         (mem_ack),
        .cycle_count (bus_count),
        .last_we     (last_we),
        .last_size   (last_size)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    function automatic test_row_t make_row(input logic [6:0] op, input logic [2:0] f3,
        input logic cmp, input logic [1:0] rw, input logic wbm, input logic alu,
        input logic [1:0] bus, input logic we, input logic [1:0] size, input logic br,
        input logic ill, input logic [3:0] lat);
        make_row = {op, f3, cmp, rw, wbm, alu, bus, we, size, br, ill, lat};
    endfunction

    task automatic load_table();
        // opcode, func3, cmp, writes, wb mem, alu_src, bus, we, size, branch, illegal, done
        rows[0]  = make_row(ctrl_pkg::OPC_OP,     0, 0, 1, 0, 0, 0, 0, SZ_B, 0, 0, 5);
        rows[1]  = make_row(ctrl_pkg::OPC_OP_IMM, 0, 0, 1, 0, 1, 0, 0, SZ_B, 0, 0, 5);
        rows[2]  = make_row(ctrl_pkg::OPC_LUI,    0, 0, 1, 0, 1, 0, 0, SZ_B, 0, 0, 5);
        rows[3]  = make_row(ctrl_pkg::OPC_AUIPC,  0, 0, 1, 0, 1, 0, 0, SZ_B, 0, 0, 5);
        rows[4]  = make_row(ctrl_pkg::OPC_LOAD,   0, 0, 1, 1, 1, 1, 0, SZ_B, 0, 0, 0);
        rows[5]  = make_row(ctrl_pkg::OPC_LOAD,   1, 0, 1, 1, 1, 1, 0, SZ_H, 0, 0, 0);
        rows[6]  = make_row(ctrl_pkg::OPC_LOAD,   2, 0, 1, 1, 1, 1, 0, SZ_W, 0, 0, 0);
        rows[7]  = make_row(ctrl_pkg::OPC_LOAD,   4, 0, 1, 1, 1, 1, 0, SZ_B, 0, 0, 0);
        rows[8]  = make_row(ctrl_pkg::OPC_LOAD,   5, 0, 1, 1, 1, 1, 0, SZ_H, 0, 0, 0);
        rows[9]  = make_row(ctrl_pkg::OPC_STORE,  0, 0, 0, 0, 1, 1, 1, SZ_B, 0, 0, 0);
        rows[10] = make_row(ctrl_pkg::OPC_STORE,  1, 0, 0, 0, 1, 1, 1, SZ_H, 0, 0, 0);
        rows[11] = make_row(ctrl_pkg::OPC_STORE,  2, 0, 0, 0, 1, 1, 1, SZ_W, 0, 0, 0);
        rows[12] = make_row(ctrl_pkg::OPC_BRANCH, 0, 1, 0, 0, 0, 0, 0, SZ_B, 1, 0, 5);
        rows[13] = make_row(ctrl_pkg::OPC_BRANCH, 1, 0, 0, 0, 0, 0, 0, SZ_B, 0, 0, 5);
        rows[14] = make_row(ctrl_pkg::OPC_JAL,    0, 0, 0, 0, 0, 0, 0, SZ_B, 0, 1, 4);
        rows[15] = make_row(ctrl_pkg::OPC_JALR,   0, 0, 0, 0, 0, 0, 0, SZ_B, 0, 1, 4);
        rows[16] = make_row(7'b1111111,           0, 0, 0, 0, 0, 0, 0, SZ_B, 0, 1, 4);
        rows[17] = make_row(ctrl_pkg::OPC_LOAD,   3, 0, 0, 0, 0, 0, 0, SZ_B, 0, 1, 5);
        rows[18] = make_row(ctrl_pkg::OPC_LOAD,   7, 0, 0, 0, 0, 0, 0, SZ_B, 0, 1, 5);
        rows[19] = make_row(ctrl_pkg::OPC_STORE,  4, 0, 0, 0, 0, 0, 0, SZ_B, 0, 1, 5);
        rows[20] = make_row(ctrl_pkg::OPC_STORE,  3, 0, 0, 0, 0, 0, 0, SZ_B, 0, 1, 5);
        rows[21] = make_row(ctrl_pkg::OPC_LOAD,   2, 0, 1, 1, 1, 1, 0, SZ_W, 0, 0, 0);
        rows[22] = make_row(ctrl_pkg::OPC_STORE,  0, 0, 0, 0, 1, 1, 1, SZ_B, 0, 0, 0);
        rows[23] = make_row(ctrl_pkg::OPC_OP,     0, 1, 1, 0, 0, 0, 0, SZ_B, 0, 0, 5);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Observer sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (active)
        begin
            rel = rel + 1;                  // Cycle index after the go sample
            if (ctrl.ir_en)
            begin
                ir_count++;
                ir_cycle = rel;
            end
            if (ctrl.pc_en && ctrl.pc_sel == ctrl_pkg::PC_SEQ)
            begin
                pc_seq_count++;
                pc_seq_cycle = rel;
            end
            if (ctrl.pc_en && ctrl.pc_sel == ctrl_pkg::PC_BRANCH)
                pc_branch_count++;
            if (ctrl.reg_write)
            begin
                write_count++;
                write_from_mem  = (ctrl.wb_src == ctrl_pkg::WB_MEM);
                write_after_ack = ack_seen;
            end
            if (mem_ack)
                ack_seen = 1;
            if (ctrl.alu_src)
                alu_seen = 1;
            if (illegal)
                illegal_cycles++;
            if (instr_done)
            begin
                done_cycle      = rel;
                illegal_at_done = illegal;
                active          = 0;
                done_flag       = 1;
            end
        end
        else if (!reset && go)
        begin
            active          = 1;
            seen_go         = 1;
            done_flag       = 0;
            rel             = 0;
            ir_count        = 0;
            pc_seq_count    = 0;
            pc_branch_count = 0;
            write_count     = 0;
            write_from_mem  = 0;
            write_after_ack = 0;
            ack_seen        = 0;
            alu_seen        = 0;
            illegal_cycles  = 0;
        end
        else if (!seen_go)
        begin
            check_value(ctrl, 32'd0, "ctrl active before first go");
            check_value({mem_req.cyc, mem_req.stb, instr_done, illegal}, 32'd0,
                        "bus or status active before first go");
        end
    end

    task automatic run_row(input int idx);
        test_row_t   row;
        logic [31:0] bus_start;
        row       = rows[idx];
        bus_start = bus_count;
        @(posedge clk);
        go         <= 1'b1;
        instr      <= {row.opcode, row.func3};
        comparator <= row.cmp;
        @(posedge clk);
        go <= 1'b0;
        wait (done_flag);
        check_value(ir_count, 1, $sformatf("row %0d ir_en pulses", idx));
        check_value(ir_cycle, 1, $sformatf("row %0d ir_en cycle", idx));
        check_value(pc_seq_count, 1, $sformatf("row %0d sequential pc_en pulses", idx));
        check_value(pc_seq_cycle, 2, $sformatf("row %0d sequential pc_en cycle", idx));
        check_value(pc_branch_count, row.branch, $sformatf("row %0d branch redirects", idx));
        check_value(write_count, row.reg_writes, $sformatf("row %0d reg_write pulses", idx));
        if (row.reg_writes != 0)
            check_value(write_from_mem, row.wb_mem, $sformatf("row %0d wb_src", idx));
        if (row.wb_mem)
            check_value(write_after_ack, 1, $sformatf("row %0d load write after ack", idx));
        check_value(alu_seen, row.alu_src, $sformatf("row %0d alu_src", idx));
        check_value(bus_count - bus_start, row.bus_cycles, $sformatf("row %0d bus cycles", idx));
        if (row.bus_cycles != 0)
        begin
            check_value(last_we, row.we, $sformatf("row %0d we", idx));
            check_value(last_size, row.size, $sformatf("row %0d size", idx));
        end
        check_value(illegal_at_done, row.illegal, $sformatf("row %0d illegal at done", idx));
        if (!row.illegal)
            check_value(illegal_cycles, 0, $sformatf("row %0d illegal raised", idx));
        if (row.latency != 0)
            check_value(done_cycle, row.latency, $sformatf("row %0d instr_done cycle", idx));
    endtask

    initial
    begin
        reset      = 1'b1;
        go         = 1'b0;
        instr      = '0;
        comparator = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Watchdog sized from the table length
    initial
    begin
        #(NUM_ROWS * 20 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("Run timed out waiting for instr_done");
        $display("TB FAILED");
        $finish;
    end

endmodule

/* bench/wb_mem_model.sv */
`timescale 1ns/10ps

module wb_mem_model
(
    input  logic                clk,
    input  logic                reset,
    input  ctrl_pkg::mem_req_t  mem_req,
    output logic                ack,
    output logic [31:0]         cycle_count,    // Completed bus cycles
    output logic                last_we,
    output ctrl_pkg::mem_size_e last_size
);

    localparam logic [15:0] LFSR_SEED = 16'd10;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic [15:0] lfsr;
    logic [15:0] lfsr_mid;
    logic [15:0] lfsr_end;
    logic [1:0]  draw;
    logic [1:0]  delay;
    logic [1:0]  wait_cnt;
    logic        busy;          // Delay already drawn for this cycle

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            lfsr_step = (s >> 1) ^ LFSR_TAPS;
        else
            lfsr_step = s >> 1;
    endfunction

    // One bit taken before each of the two steps per delay
    always_comb
    begin
        lfsr_mid = lfsr_step(lfsr);
        lfsr_end = lfsr_step(lfsr_mid);
        draw     = {lfsr[0], lfsr_mid[0]};
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            lfsr        <= LFSR_SEED;
            ack         <= 1'b0;
            busy        <= 1'b0;
            delay       <= 2'd0;
            wait_cnt    <= 2'd0;
            cycle_count <= 32'd0;
            last_we     <= 1'b0;
            last_size   <= ctrl_pkg::SIZE_BYTE;
        end
        else
        begin
            ack <= 1'b0;
            if (mem_req.cyc && mem_req.stb && !ack)
            begin
                if (!busy)
                begin
                    busy     <= 1'b1;
                    lfsr     <= lfsr_end;
                    delay    <= draw;
                    wait_cnt <= 2'd1;
                    if (draw == 2'd0)
                        ack <= 1'b1;        // No wait cycles
                end
                else if (wait_cnt == delay)
                    ack <= 1'b1;
                else
                    wait_cnt <= wait_cnt + 2'd1;
            end
            if (ack)
            begin
                // Master samples ack on this edge
                busy        <= 1'b0;
                cycle_count <= cycle_count + 32'd1;
                last_we     <= mem_req.we;
                last_size   <= mem_req.size;
            end
        end
    end

endmodule

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    // RV32I major opcodes
    typedef enum logic [6:0]
    {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // Fields of the instruction register that the controller looks at
    typedef struct packed
    {
        opcode_e    opcode;
        logic [2:0] func3;
    } instr_fields_t;

    // Dispatch classes, one per execution unit behaviour
    typedef enum logic [2:0]
    {
        CLS_REG_REG,
        CLS_REG_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH
    } instr_class_e;

    //////////////////////////////////////////////////////////////////////
    // Datapath and bus controls
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

    typedef enum logic {WB_ALU, WB_MEM} wb_src_e;      // Register file write source

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH} pc_sel_e;

    typedef struct packed
    {
        logic    ir_en;       // Load instruction register
        logic    pc_en;       // Update program counter
        pc_sel_e pc_sel;
        logic    alu_src;     // ALU operand b from immediate
        logic    reg_write;
        wb_src_e wb_src;
    } ctrl_out_t;

    // Wishbone classic master outputs; address lives in the datapath
    typedef struct packed
    {
        logic      cyc;
        logic      stb;
        logic      we;
        mem_size_e size;
    } mem_req_t;

endpackage

/* hw/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  ctrl_pkg::instr_class_e  instr_class,
    input  logic                    comparator,
    output ctrl_pkg::ctrl_out_t     exec_ctrl,
    output logic                    done
);

    ctrl_pkg::ctrl_out_t action;    // Controls for the single action cycle

    always_comb
    begin
        action        = '0;
        action.pc_sel = ctrl_pkg::PC_SEQ;
        action.wb_src = ctrl_pkg::WB_ALU;
        if (start)
        begin
            case (instr_class)
                ctrl_pkg::CLS_REG_REG:
                begin
                    action.reg_write = 1'b1;
                end
                ctrl_pkg::CLS_REG_IMM:
                begin
                    action.reg_write = 1'b1;
                    action.alu_src   = 1'b1;    // Immediate into ALU b
                end
                ctrl_pkg::CLS_BRANCH:
                begin
                    // Redirect only when the datapath compare holds
                    action.pc_en  = comparator;
                    action.pc_sel = comparator ? ctrl_pkg::PC_BRANCH : ctrl_pkg::PC_SEQ;
                end
                default:
                begin
                    action = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            exec_ctrl <= '0;
            done      <= 1'b0;
        end
        else
        begin
            exec_ctrl <= action;
            done      <= start;     // Action and done share cycle s+1
        end
    end

    a_no_write_with_redirect: assert property
        (@(posedge clk) disable iff (reset) !(exec_ctrl.reg_write && exec_ctrl.pc_en))
        else $error("reg_write and pc_en high together");

endmodule

/* hw/instr_sequencer.sv */
`timescale 1ns/10ps

module instr_sequencer
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    go,
    input  ctrl_pkg::opcode_e       opcode,
    input  ctrl_pkg::ctrl_out_t     exec_ctrl,
    input  ctrl_pkg::ctrl_out_t     mem_ctrl,
    input  logic                    exec_done,
    input  logic                    mem_done,
    output logic                    start_exec,
    output logic                    start_mem,
    output ctrl_pkg::instr_class_e  instr_class,
    output ctrl_pkg::ctrl_out_t     ctrl,
    output logic                    instr_done,
    output logic                    illegal_op
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_FETCH,
        S_PC_UPD,
        S_DISPATCH,
        S_WAIT,
        S_COMPLETE
    } seq_state_e;

    seq_state_e state;
    seq_state_e next_state;
    logic       is_legal;
    logic       use_mem;
    logic       illegal_q;      // Dispatch found no unit for the opcode

    //////////////////////////////////////////////////////////////////////
    // Opcode dispatch
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        is_legal    = 1'b1;
        instr_class = ctrl_pkg::CLS_REG_REG;
        case (opcode)
            ctrl_pkg::OPC_OP:     instr_class = ctrl_pkg::CLS_REG_REG;
            ctrl_pkg::OPC_OP_IMM,
            ctrl_pkg::OPC_LUI,
            ctrl_pkg::OPC_AUIPC:  instr_class = ctrl_pkg::CLS_REG_IMM;   // Immediate operand path
            ctrl_pkg::OPC_LOAD:   instr_class = ctrl_pkg::CLS_LOAD;
            ctrl_pkg::OPC_STORE:  instr_class = ctrl_pkg::CLS_STORE;
            ctrl_pkg::OPC_BRANCH: instr_class = ctrl_pkg::CLS_BRANCH;
            ctrl_pkg::OPC_JAL,
            ctrl_pkg::OPC_JALR:   is_legal = 1'b0;       // Jumps not supported
            default:              is_legal = 1'b0;
        endcase
    end

    assign use_mem = (instr_class == ctrl_pkg::CLS_LOAD) ||
                     (instr_class == ctrl_pkg::CLS_STORE);

    assign start_exec = (state == S_DISPATCH) && is_legal && !use_mem;
    assign start_mem  = (state == S_DISPATCH) && is_legal && use_mem;

    //////////////////////////////////////////////////////////////////////
    // Main FSM
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:     next_state = go ? S_FETCH : S_IDLE;
            S_FETCH:    next_state = S_PC_UPD;
            S_PC_UPD:   next_state = S_DISPATCH;
            S_DISPATCH: next_state = is_legal ? S_WAIT : S_COMPLETE;
            S_WAIT:
            begin
                if (exec_done || mem_done)
                    next_state = S_COMPLETE;
            end
            S_COMPLETE: next_state = go ? S_FETCH : S_IDLE;   // Back-to-back start allowed
            default:    next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= S_IDLE;
            illegal_q <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == S_DISPATCH)
                illegal_q <= !is_legal;
        end
    end

    assign instr_done = (state == S_COMPLETE);
    assign illegal_op = instr_done && illegal_q;

    // Merge own fetch/PC strobes with the unit contributions
    always_comb
    begin
        ctrl.ir_en     = (state == S_FETCH) | exec_ctrl.ir_en | mem_ctrl.ir_en;
        ctrl.pc_en     = (state == S_PC_UPD) | exec_ctrl.pc_en | mem_ctrl.pc_en;
        ctrl.pc_sel    = (exec_ctrl.pc_sel == ctrl_pkg::PC_BRANCH) ?
                         ctrl_pkg::PC_BRANCH : ctrl_pkg::PC_SEQ;
        ctrl.alu_src   = exec_ctrl.alu_src | mem_ctrl.alu_src;
        ctrl.reg_write = exec_ctrl.reg_write | mem_ctrl.reg_write;
        ctrl.wb_src    = (mem_ctrl.wb_src == ctrl_pkg::WB_MEM) ?
                         ctrl_pkg::WB_MEM : ctrl_pkg::WB_ALU;
    end

    // Unit outputs must never overlap the fetch strobe
    a_no_fetch_with_pc_update: assert property
        (@(posedge clk) disable iff (reset) !(ctrl.ir_en && ctrl.pc_en))
        else $error("ir_en and pc_en high in the same cycle");

endmodule

/* hw/mem_access_unit.sv */
`timescale 1ns/10ps

module mem_access_unit
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  ctrl_pkg::instr_class_e  instr_class,
    input  logic [2:0]              func3,
    input  logic                    mem_ack,
    output ctrl_pkg::mem_req_t      mem_req,
    output ctrl_pkg::ctrl_out_t     mem_ctrl,
    output logic                    done,
    output logic                    illegal_size
);

    typedef enum logic [2:0] {M_IDLE, M_REQ, M_DONE, M_BAD, M_BAD_HOLD} mem_state_e;

    mem_state_e          state;
    logic                is_load;
    logic                size_ok;
    ctrl_pkg::mem_size_e size_d;
    ctrl_pkg::mem_size_e size_q;
    logic                we_q;

    assign is_load = (instr_class == ctrl_pkg::CLS_LOAD);

    // func3 to access size; 4 and 5 are the unsigned loads
    always_comb
    begin
        size_ok = 1'b1;
        size_d  = ctrl_pkg::SIZE_WORD;
        case (func3)
            3'd0: size_d = ctrl_pkg::SIZE_BYTE;
            3'd1: size_d = ctrl_pkg::SIZE_HALF;
            3'd2: size_d = ctrl_pkg::SIZE_WORD;
            3'd4:
            begin
                size_d  = ctrl_pkg::SIZE_BYTE;
                size_ok = is_load;
            end
            3'd5:
            begin
                size_d  = ctrl_pkg::SIZE_HALF;
                size_ok = is_load;
            end
            default: size_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state  <= M_IDLE;
            we_q   <= 1'b0;
            size_q <= ctrl_pkg::SIZE_BYTE;
        end
        else
        begin
            case (state)
                M_IDLE:
                begin
                    if (start)
                    begin
                        we_q   <= !is_load;
                        size_q <= size_d;
                        state  <= size_ok ? M_REQ : M_BAD;
                    end
                end
                M_REQ:      if (mem_ack) state <= M_DONE;   // Hold request until ack
                M_DONE:     state <= M_IDLE;
                M_BAD:      state <= M_BAD_HOLD;
                default:    state <= M_IDLE;
            endcase
        end
    end

    always_comb
    begin
        mem_req.cyc  = (state == M_REQ);
        mem_req.stb  = (state == M_REQ);
        mem_req.we   = we_q;
        mem_req.size = size_q;

        mem_ctrl           = '0;
        mem_ctrl.pc_sel    = ctrl_pkg::PC_SEQ;
        mem_ctrl.alu_src   = (state == M_REQ) || (state == M_DONE);   // Address = rs1 + imm
        mem_ctrl.reg_write = (state == M_DONE) && !we_q;
        mem_ctrl.wb_src    = mem_ctrl.reg_write ? ctrl_pkg::WB_MEM : ctrl_pkg::WB_ALU;
    end

    assign done = (state == M_DONE) || (state == M_BAD);

    // Illegal stays up through the sequencer's completion cycle
    assign illegal_size = (state == M_BAD) || (state == M_BAD_HOLD);

    a_stb_needs_cyc: assert property
        (@(posedge clk) disable iff (reset) mem_req.stb |-> mem_req.cyc)
        else $error("stb without cyc");

    a_req_held: assert property
        (@(posedge clk) disable iff (reset)
            (mem_req.cyc && !mem_ack) |=>
            (mem_req.cyc && mem_req.stb && $stable(mem_req.we) && $stable(mem_req.size)))
        else $error("Wishbone request changed before ack");

endmodule

/* hw/multicycle_controller.sv */
`timescale 1ns/10ps

module multicycle_controller
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    go,
    input  ctrl_pkg::instr_fields_t instr,
    input  logic                    comparator,
    input  logic                    mem_ack,
    output ctrl_pkg::ctrl_out_t     ctrl,
    output ctrl_pkg::mem_req_t      mem_req,
    output logic                    instr_done,
    output logic                    illegal
);

    ctrl_pkg::ctrl_out_t    exec_ctrl;
    ctrl_pkg::ctrl_out_t    mem_ctrl;
    ctrl_pkg::instr_class_e instr_class;
    logic                   start_exec;
    logic                   start_mem;
    logic                   exec_done;
    logic                   mem_done;
    logic                   illegal_op;
    logic                   illegal_size;

    //////////////////////////////////////////////////////////////////////
    // Sequencer and execution units
    //////////////////////////////////////////////////////////////////////

    instr_sequencer sequencer_i
    (
        .clk         (clk),
        .reset       (reset),
        .go          (go),
        .opcode      (instr.opcode),
        .exec_ctrl   (exec_ctrl),
        .mem_ctrl    (mem_ctrl),
        .exec_done   (exec_done),
        .mem_done    (mem_done),
        .start_exec  (start_exec),
        .start_mem   (start_mem),
        .instr_class (instr_class),
        .ctrl        (ctrl),
        .instr_done  (instr_done),
        .illegal_op  (illegal_op)
    );

    execute_unit execute_i
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start_exec),
        .instr_class (instr_class),
        .comparator  (comparator),
        .exec_ctrl   (exec_ctrl),
        .done        (exec_done)
    );

    mem_access_unit mem_access_i
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start_mem),
        .instr_class  (instr_class),
        .func3        (instr.func3),
        .mem_ack      (mem_ack),
        .mem_req      (mem_req),
        .mem_ctrl     (mem_ctrl),
        .done         (mem_done),
        .illegal_size (illegal_size)
    );

    assign illegal = illegal_op | illegal_size;     // Opcode or access size fault

endmodule
